//--- tb/spi_vectors.txt
// kind op len nchk payload(12) rotation speed exp_read exp_rgb exp_pattern, hex, no spaces
// kind 00 readback, 01 configuration, 02 control, 03 malformed frame, FF ends the list
00100300000000000000A5C31234A5C30000
001103000000000000000F0F7E817E810000
010107008001C0FFEE420000000000000000
020202020200000000000000000000000001
020202440300000000000000000000000101
030203020500000000000000000000000101
030702020400000000000000000000000101
03010602FFFFFFFFFFFF0000000000000101
020202020500000000000000000000000102
001003000000000000003C5A99993C5A0101
01010700123456789ABC0000000000000101
020202020100000000000000000000000100
FF0000000000000000000000000000000000

//--- build.f
common/spi_cmd_pkg.sv
common/led_drv_pkg.sv
spi/spi_slave.sv
spi/spi_decoder.sv
driver/column_source.sv
driver/lane_shifter.sv
driver/driver_sequencer.sv
verilog/pov_display_top.sv
tb/pov_display_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and grade the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module pov_display_tb \
    -o pov_display_sim \
    && ./obj_dir/pov_display_sim | tee sim.log \
    || { echo "run_sim: build or simulation did not complete"; exit 1; }

grep -q "SIMULATION PASSED" sim.log \
    && { echo "run_sim: pass"; exit 0; } \
    || { echo "run_sim: fail"; exit 1; }

//--- tb/pov_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pov_display_tb;

    localparam int NUM_LANES = 8;
    localparam int CLK_DIV = 4;
    localparam int BLANKING_CYCLES = 72;
    localparam int NUM_COLUMNS = 64;
    localparam int MAX_VECTORS = 16;
    // one load, 49 sclk periods, latch and blanking, with some slack
    localparam int COLUMN_CLKS = CLK_DIV * (2 * 49 + 2 + BLANKING_CYCLES) + 8;
    // seven bytes at 16 clocks per bit plus the ss gaps
    localparam int FRAME_CLKS = 7 * 8 * 16 + 64;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 spi_clk;
    logic                 spi_ss;
    logic                 spi_mosi;
    logic [15:0]          rotation_data;
    logic [15:0]          speed_data;
    logic                 spi_miso;
    logic                 sclk;
    logic                 lat;
    logic                 gclk;
    logic                 rgb_enable;
    logic [NUM_LANES-1:0] sin;

    logic [143:0] vectors [MAX_VECTORS];
    logic [48:0]  shifted [NUM_LANES];
    logic [48:0]  latched [NUM_LANES];
    logic         sclk_q = 1'b0;
    logic         lat_q = 1'b0;
    logic         gclk_q = 1'b0;
    int           blank_left = 0;
    int           latch_count = 0;
    int           gray_count = 0;
    int           latch_col = 0;
    int           err_count = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           cycles = 0;
    int           cycle_limit = 1000000;

    pov_display_top #(
        .NUM_LANES(NUM_LANES),
        .CLK_DIV(CLK_DIV),
        .BLANKING_CYCLES(BLANKING_CYCLES),
        .NUM_COLUMNS(NUM_COLUMNS)
    ) u_pov_display_top (
        .clk(clk),
        .rst_n(rst_n),
        .spi_clk(spi_clk),
        .spi_ss(spi_ss),
        .spi_mosi(spi_mosi),
        .rotation_data(rotation_data),
        .speed_data(speed_data),
        .spi_miso(spi_miso),
        .sclk(sclk),
        .lat(lat),
        .gclk(gclk),
        .rgb_enable(rgb_enable),
        .sin(sin)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // lanes shift msb first, one bit per rising sclk
    always @(negedge clk) begin : capture
        int i;
        if (sclk && !sclk_q) begin
            for (i = 0; i < NUM_LANES; i++) begin
                shifted[i] = {shifted[i][47:0], sin[i]};
            end
        end
        // gclk moves on every sclk edge while shifting
        if (sclk != sclk_q) begin
            compare(64'(gclk != gclk_q), 64'd1, "gclk toggle on sclk edge");
        end
        if (lat && !lat_q) begin
            for (i = 0; i < NUM_LANES; i++) begin
                latched[i] = shifted[i];
            end
            // only grayscale loads advance the column
            if (!shifted[0][48]) begin
                latch_col = gray_count % NUM_COLUMNS;
                gray_count++;
            end
            latch_count++;
        end
        // blanking starts as lat drops
        if (!lat && lat_q) begin
            blank_left = BLANKING_CYCLES * CLK_DIV;
        end
        if (blank_left > 0) begin
            compare(64'(gclk), 64'd0, "gclk during blanking");
            blank_left--;
        end
        sclk_q = sclk;
        lat_q = lat;
        gclk_q = gclk;
    end

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // red is the column, green the lane, blue the inverted column
    function automatic logic [48:0] expected_gray(input logic rgb, input logic [1:0] pat,
                                                  input int lane, input int col);
        logic [15:0] c;
        logic [15:0] l;
        logic [48:0] w;
        c = col[15:0];
        l = lane[15:0];
        w = '0;
        if (rgb && pat == 2'd1) begin
            w = {1'b0, c, l, ~c};
        end else if (rgb && pat == 2'd2) begin
            w = {1'b0, {48{1'b1}}};
        end
        return w;
    endfunction

    task automatic wait_latch();
        int start;
        start = latch_count;
        while (latch_count == start) begin
            @(posedge clk);
        end
    endtask

    // mode 0 host, spi_clk toggles every 8 clocks
    task automatic send_frame(input logic [55:0] frame, input int nbytes,
                              output logic [15:0] resp);
        int i;
        resp = '0;
        @(posedge clk);
        spi_ss <= 1'b0;
        repeat (8) @(posedge clk);
        for (i = 0; i < nbytes * 8; i++) begin
            spi_mosi <= frame[55 - i];
            repeat (7) @(posedge clk);
            @(negedge clk);
            if (i >= 8 && i < 24) begin
                resp = {resp[14:0], spi_miso};
            end
            @(posedge clk);
            spi_clk <= 1'b1;
            repeat (8) @(posedge clk);
            spi_clk <= 1'b0;
        end
        repeat (8) @(posedge clk);
        spi_ss <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic check_gray_lanes(input logic rgb, input logic [1:0] pat);
        int i;
        for (i = 0; i < NUM_LANES; i++) begin
            compare(64'(latched[i]), 64'(expected_gray(rgb, pat, i, latch_col)),
                    $sformatf("lane %0d grayscale shift, column %0d", i, latch_col));
        end
    endtask

    task automatic check_conf_lanes(input logic [47:0] conf);
        int i;
        for (i = 0; i < NUM_LANES; i++) begin
            compare(64'(latched[i]), 64'({1'b1, conf}),
                    $sformatf("lane %0d configuration shift", i));
        end
    endtask

    task automatic run_test(input logic [143:0] v, input int idx);
        logic [7:0]  kind;
        logic [15:0] resp;
        logic        found;
        int          nchk;
        int          errs_before;
        int          k;
        string       name;
        kind = v[143:136];
        nchk = int'(v[119:112]);
        errs_before = err_count;
        @(posedge clk);
        rotation_data <= v[63:48];
        speed_data <= v[47:32];
        send_frame({v[135:128], v[111:64]}, int'(v[127:120]), resp);
        case (kind)
            8'h00: begin
                name = "readback";
                compare(64'(resp), 64'(v[31:16]), "miso readback");
            end
            8'h01: begin
                name = "configuration";
                found = 1'b0;
                // the shift in flight may still be grayscale
                for (k = 0; k < 2 && !found; k++) begin
                    wait_latch();
                    found = latched[0][48];
                end
                compare(64'(found), 64'd1, "configuration shift after frame");
                if (found) begin
                    check_conf_lanes(v[111:64]);
                end
            end
            default: begin
                name = (kind == 8'h02) ? "control" : "malformed frame";
                compare(64'(rgb_enable), 64'(v[8]), "rgb_enable");
                wait_latch();
                compare(64'(latched[0][48]), 64'd0, "control flag of next shift");
                for (k = 0; k < nchk; k++) begin
                    wait_latch();
                    check_gray_lanes(v[8], v[1:0]);
                end
            end
        endcase
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", idx, name, (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int t;
        rst_n = 1'b0;
        spi_clk = 1'b0;
        spi_ss = 1'b1;
        spi_mosi = 1'b0;
        rotation_data = '0;
        speed_data = '0;
        for (t = 0; t < MAX_VECTORS; t++) begin
            vectors[t] = '1;
        end
        $readmemh("tb/spi_vectors.txt", vectors);
        cycle_limit = 4000;
        for (t = 0; t < MAX_VECTORS && vectors[t][143:136] != 8'hFF; t++) begin
            cycle_limit += FRAME_CLKS + (int'(vectors[t][119:112]) + 3) * COLUMN_CLKS;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        for (t = 0; t < MAX_VECTORS && vectors[t][143:136] != 8'hFF; t++) begin
            run_test(vectors[t], t);
        end
        if (tests_run == 0) begin
            err_count++;
            $display("No test vectors were read from tb/spi_vectors.txt");
        end
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pov_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module pov_display_top #(
    parameter int NUM_LANES = 8,
    parameter int CLK_DIV = 4,
    parameter int BLANKING_CYCLES = 72,
    parameter int NUM_COLUMNS = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 spi_clk,
    input  logic                 spi_ss,
    input  logic                 spi_mosi,
    input  logic [15:0]          rotation_data,
    input  logic [15:0]          speed_data,
    output logic                 spi_miso,
    output logic                 sclk,
    output logic                 lat,
    output logic                 gclk,
    output logic                 rgb_enable,
    output logic [NUM_LANES-1:0] sin
);

    spi_cmd_pkg::cmd_word_t  cmd_read;
    logic [2:0]              cmd_len_bytes;
    logic [15:0]             cmd_write;
    logic                    byte_valid;
    logic                    frame_done;
    logic [47:0]             conf_word;
    logic                    new_conf;
    led_drv_pkg::pattern_e   pattern;
    logic                    load_req;
    logic                    load_grayscale;
    logic                    load_conf;
    logic                    shift_en;
    logic [NUM_LANES*48-1:0] lane_words;
    logic                    words_valid;

    spi_slave u_spi_slave (
        .clk(clk),
        .rst_n(rst_n),
        .spi_clk(spi_clk),
        .spi_ss(spi_ss),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .byte_valid(byte_valid),
        .frame_done(frame_done),
        .cmd_read(cmd_read),
        .cmd_len_bytes(cmd_len_bytes),
        .cmd_write(cmd_write)
    );

    spi_decoder u_spi_decoder (
        .clk(clk),
        .rst_n(rst_n),
        .byte_valid(byte_valid),
        .frame_done(frame_done),
        .cmd_read(cmd_read),
        .cmd_len_bytes(cmd_len_bytes),
        .rotation_data(rotation_data),
        .speed_data(speed_data),
        .cmd_write(cmd_write),
        .conf_word(conf_word),
        .new_conf(new_conf),
        .rgb_enable(rgb_enable),
        .pattern(pattern)
    );

    column_source #(
        .NUM_LANES(NUM_LANES),
        .NUM_COLUMNS(NUM_COLUMNS)
    ) u_column_source (
        .clk(clk),
        .rst_n(rst_n),
        .load_req(load_req),
        .rgb_enable(rgb_enable),
        .pattern(pattern),
        .lane_words(lane_words),
        .words_valid(words_valid)
    );

    driver_sequencer #(
        .CLK_DIV(CLK_DIV),
        .BLANKING_CYCLES(BLANKING_CYCLES)
    ) u_driver_sequencer (
        .clk(clk),
        .rst_n(rst_n),
        .new_conf(new_conf),
        .words_valid(words_valid),
        .load_req(load_req),
        .load_grayscale(load_grayscale),
        .load_conf(load_conf),
        .shift_en(shift_en),
        .sclk(sclk),
        .lat(lat),
        .gclk(gclk)
    );

    // one shifter per driver lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lane_shifter u_lane_shifter (
            .clk(clk),
            .rst_n(rst_n),
            .load_grayscale(load_grayscale),
            .load_conf(load_conf),
            .shift_en(shift_en),
            .word(lane_words[g*48 +: 48]),
            .conf_word(conf_word),
            .sin(sin[g])
        );
    end

endmodule

`default_nettype wire

//--- driver/driver_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module driver_sequencer #(
    parameter int CLK_DIV = 4,
    parameter int BLANKING_CYCLES = 72
) (
    input  logic clk,
    input  logic rst_n,
    input  logic new_conf,
    input  logic words_valid,
    output logic load_req,
    output logic load_grayscale,
    output logic load_conf,
    output logic shift_en,
    output logic sclk,
    output logic lat,
    output logic gclk
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int BIT_W = $clog2(led_drv_pkg::SHIFT_BITS);
    localparam int BLANK_W = $clog2(BLANKING_CYCLES + 1);

    typedef enum logic [2:0] {
        S_LOAD,
        S_WAIT,
        S_SHIFT,
        S_LATCH,
        S_BLANK
    } state_t;

    state_t             state;
    logic [DIV_W-1:0]   div_cnt;
    logic               tick;
    logic [BIT_W-1:0]   bit_cnt;
    logic [BLANK_W-1:0] blank_cnt;
    logic               conf_pending;

    assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));

    // grayscale words are taken the same clock they show up
    assign load_grayscale = (state == S_WAIT) && words_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_LOAD;
            div_cnt <= '0;
            bit_cnt <= '0;
            blank_cnt <= '0;
            conf_pending <= 1'b0;
            load_req <= 1'b0;
            load_conf <= 1'b0;
            shift_en <= 1'b0;
            sclk <= 1'b0;
            lat <= 1'b0;
            gclk <= 1'b0;
        end else begin
            load_req <= 1'b0;
            load_conf <= 1'b0;
            shift_en <= 1'b0;
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            // config arriving mid-shift waits for the next load step
            if (new_conf) begin
                conf_pending <= 1'b1;
            end
            if (tick) begin
                gclk <= (state == S_BLANK || state == S_LATCH) ? 1'b0 : ~gclk;
            end
            case (state)
                S_LOAD: begin
                    if (tick) begin
                        bit_cnt <= '0;
                        if (conf_pending) begin
                            load_conf <= 1'b1;
                            conf_pending <= new_conf;
                            state <= S_SHIFT;
                        end else begin
                            load_req <= 1'b1;
                            state <= S_WAIT;
                        end
                    end
                end
                S_WAIT: begin
                    if (words_valid) begin
                        state <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    // sclk high one tick, low the next
                    if (tick) begin
                        if (!sclk) begin
                            sclk <= 1'b1;
                            shift_en <= 1'b1;
                        end else begin
                            sclk <= 1'b0;
                            if (bit_cnt == BIT_W'(led_drv_pkg::SHIFT_BITS - 1)) begin
                                lat <= 1'b1;
                                state <= S_LATCH;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                S_LATCH: begin
                    if (tick) begin
                        lat <= 1'b0;
                        blank_cnt <= '0;
                        state <= S_BLANK;
                    end
                end
                S_BLANK: begin
                    if (tick) begin
                        if (blank_cnt == BLANK_W'(BLANKING_CYCLES - 1)) begin
                            state <= S_LOAD;
                        end else begin
                            blank_cnt <= blank_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_LOAD;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- driver/lane_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module lane_shifter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_grayscale,
    input  logic        load_conf,
    input  logic        shift_en,
    input  logic [47:0] word,
    input  logic [47:0] conf_word,
    output logic        sin
);

    localparam int WORD_W = led_drv_pkg::LANE_WORD_BITS;

    logic [led_drv_pkg::SHIFT_BITS-1:0] shift_reg;

    // msb first, flag bit goes out ahead of the data
    assign sin = shift_reg[led_drv_pkg::SHIFT_BITS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_reg <= '0;
        end else if (load_conf) begin
            shift_reg[WORD_W-1:0] <= conf_word;
            shift_reg[led_drv_pkg::CTRL_FLAG_POS] <= 1'b1;
        end else if (load_grayscale) begin
            shift_reg[WORD_W-1:0] <= word;
            shift_reg[led_drv_pkg::CTRL_FLAG_POS] <= 1'b0;
        end else if (shift_en) begin
            shift_reg <= {shift_reg[led_drv_pkg::SHIFT_BITS-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- driver/column_source.sv
`timescale 1ns/1ps
`default_nettype none

module column_source #(
    parameter int NUM_LANES = 8,
    parameter int NUM_COLUMNS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_req,
    input  logic                        rgb_enable,
    input  led_drv_pkg::pattern_e       pattern,
    output logic [NUM_LANES*48-1:0]     lane_words,
    output logic                        words_valid
);

    localparam int CW = led_drv_pkg::COLOR_BITS;
    localparam int WORD_W = led_drv_pkg::LANE_WORD_BITS;
    localparam int COL_W = (NUM_COLUMNS > 1) ? $clog2(NUM_COLUMNS) : 1;

    logic [COL_W-1:0]            col;
    logic [CW-1:0]               col_val;
    logic [NUM_LANES*WORD_W-1:0] next_words;

    assign col_val = {{(CW - COL_W){1'b0}}, col};

    // stands in for a framebuffer column read
    always_comb begin
        next_words = '0;
        if (rgb_enable) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                case (pattern)
                    led_drv_pkg::RAMP:
                        next_words[i*WORD_W +: WORD_W] = {col_val, i[CW-1:0], ~col_val};
                    led_drv_pkg::SOLID:
                        next_words[i*WORD_W +: WORD_W] = '1;
                    default:
                        next_words[i*WORD_W +: WORD_W] = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            lane_words <= next_words;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            words_valid <= 1'b0;
        end else begin
            words_valid <= load_req;
            if (load_req) begin
                col <= (col == COL_W'(NUM_COLUMNS - 1)) ? '0 : col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- spi/spi_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module spi_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   byte_valid,
    input  logic                   frame_done,
    input  spi_cmd_pkg::cmd_word_t cmd_read,
    input  logic [2:0]             cmd_len_bytes,
    input  logic [15:0]            rotation_data,
    input  logic [15:0]            speed_data,
    output logic [15:0]            cmd_write,
    output logic [47:0]            conf_word,
    output logic                   new_conf,
    output logic                   rgb_enable,
    output led_drv_pkg::pattern_e  pattern
);

    logic [7:0]                opcode;
    spi_cmd_pkg::spi_payload_u payload;

    assign opcode = cmd_read[spi_cmd_pkg::CMD_BITS-1 -: 8];
    assign payload = cmd_read[spi_cmd_pkg::PAYLOAD_BITS-1:0];

    // sensor words are sampled as soon as the opcode is in
    always_ff @(posedge clk) begin
        if (byte_valid && cmd_len_bytes == spi_cmd_pkg::OPCODE_LEN) begin
            case (opcode)
                spi_cmd_pkg::OP_READ_ROT:   cmd_write <= rotation_data;
                spi_cmd_pkg::OP_READ_SPEED: cmd_write <= speed_data;
                default:                    cmd_write <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done && cmd_len_bytes == spi_cmd_pkg::CONF_FRAME_LEN &&
                opcode == spi_cmd_pkg::OP_WRITE_CONF) begin
            conf_word <= payload.conf_word;
        end
    end

    // writes apply only once the frame closes with the right length
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_conf <= 1'b0;
            rgb_enable <= 1'b0;
            pattern <= led_drv_pkg::BLANK;
        end else begin
            new_conf <= frame_done && cmd_len_bytes == spi_cmd_pkg::CONF_FRAME_LEN &&
                        opcode == spi_cmd_pkg::OP_WRITE_CONF;
            if (frame_done && cmd_len_bytes == spi_cmd_pkg::CTRL_FRAME_LEN &&
                    opcode == spi_cmd_pkg::OP_WRITE_CTRL) begin
                rgb_enable <= payload.ctrl.rgb_enable;
                pattern <= led_drv_pkg::pattern_e'(payload.ctrl.pattern);
            end
        end
    end

endmodule

`default_nettype wire

//--- spi/spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  spi_clk,
    input  logic                  spi_ss,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    output logic                  byte_valid,
    output logic                  frame_done,
    output spi_cmd_pkg::cmd_word_t cmd_read,
    output logic [2:0]            cmd_len_bytes,
    input  logic [15:0]           cmd_write
);

    // [1] is the synchronized value, [2] the previous one
    logic [2:0]  sclk_sync;
    logic [2:0]  ss_sync;
    logic [1:0]  mosi_sync;
    logic        sclk_rise;
    logic        sclk_fall;
    logic        ss_rise;
    logic        ss_fall;
    logic        ss_active;
    logic [2:0]  bit_cnt;
    logic [2:0]  byte_cnt;
    logic [6:0]  rx_byte;
    logic        byte_valid_d;
    logic [15:0] tx_shift;

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign ss_rise = ss_sync[1] & ~ss_sync[2];
    assign ss_fall = ~ss_sync[1] & ss_sync[2];
    assign ss_active = ~ss_sync[1];
    assign cmd_len_bytes = byte_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            ss_sync <= '1;
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clk};
            ss_sync <= {ss_sync[1:0], spi_ss};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    // byte assembly into the left-aligned frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            byte_cnt <= '0;
            rx_byte <= '0;
            cmd_read <= '0;
            byte_valid <= 1'b0;
            byte_valid_d <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            byte_valid_d <= byte_valid;
            frame_done <= ss_rise;
            if (ss_fall) begin
                bit_cnt <= '0;
                byte_cnt <= '0;
                cmd_read <= '0;
            end else if (ss_active && sclk_rise) begin
                rx_byte <= {rx_byte[5:0], mosi_sync[1]};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7 && byte_cnt < spi_cmd_pkg::CMD_BYTES) begin
                    cmd_read[spi_cmd_pkg::CMD_BITS - 1 - 8 * byte_cnt -: 8] <=
                        {rx_byte, mosi_sync[1]};
                    byte_cnt <= byte_cnt + 3'd1;
                    byte_valid <= 1'b1;
                end
            end
        end
    end

    // response goes out in the two bytes after the opcode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= '0;
            spi_miso <= 1'b0;
        end else if (!ss_active) begin
            tx_shift <= '0;
            spi_miso <= 1'b0;
        end else if (byte_valid_d && byte_cnt == spi_cmd_pkg::OPCODE_LEN) begin
            tx_shift <= cmd_write;
        end else if (sclk_fall) begin
            spi_miso <= tx_shift[15];
            tx_shift <= {tx_shift[14:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- common/led_drv_pkg.sv
`default_nettype none

package led_drv_pkg;

    localparam int COLOR_BITS = 16;

    // red on top, then green, then blue
    localparam int LANE_WORD_BITS = 3 * COLOR_BITS;

    // one extra bit selects config or grayscale latch
    localparam int SHIFT_BITS = LANE_WORD_BITS + 1;
    localparam int CTRL_FLAG_POS = LANE_WORD_BITS;

    typedef enum logic [1:0] {
        BLANK = 2'd0,
        RAMP  = 2'd1,
        SOLID = 2'd2
    } pattern_e;

endpackage

`default_nettype wire

//--- common/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

    // longest frame, opcode byte plus six payload bytes
    localparam int CMD_BYTES = 7;
    localparam int CMD_BITS = CMD_BYTES * 8;
    localparam int PAYLOAD_BITS = 48;

    // frame lengths accepted per opcode
    localparam logic [2:0] OPCODE_LEN = 3'd1;
    localparam logic [2:0] CTRL_FRAME_LEN = 3'd2;
    localparam logic [2:0] CONF_FRAME_LEN = 3'd7;

    localparam logic [7:0] OP_WRITE_CONF = 8'h01;
    localparam logic [7:0] OP_WRITE_CTRL = 8'h02;
    localparam logic [7:0] OP_READ_ROT = 8'h10;
    localparam logic [7:0] OP_READ_SPEED = 8'h11;

    // first byte received sits in the top byte
    typedef logic [CMD_BITS-1:0] cmd_word_t;

    typedef struct packed {
        logic [4:0]  spare;
        logic [1:0]  pattern;
        logic        rgb_enable;
        logic [39:0] ignored;
    } ctrl_payload_t;

    typedef union packed {
        logic [PAYLOAD_BITS-1:0] conf_word;
        ctrl_payload_t           ctrl;
    } spi_payload_u;

endpackage

`default_nettype wire
